// ==== flist.f ====
hw/mpf_pkg.sv
hw/mpf_req_queue.sv
hw/mpf_chan_arbiter.sv
hw/mpf_vtp.sv
hw/mpf_rsp_order.sv
hw/mpf_shim_stack.sv
test/mpf_mem_model.sv
test/mpf_tb.sv

// ==== Makefile ====
# Verilator build and run for the MPF shim stack testbench

VERILATOR ?= verilator
TOP ?= mpf_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SOURCES := $(shell cat $(FLIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/mpf_tb.sv ====
// Testbench for the MPF shim stack with clock, reset, LCG stimulus, reference model and watchdog
`timescale 1ns/10ps

module mpf_tb;

    // ====================
    // Run lengths
    // ====================

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    localparam int idle_cycles = 10;
    localparam int basic_cycles = 400;
    localparam int pt_rounds = 4;
    localparam int pt_cycles = 100;
    localparam int order_cycles = 300;
    localparam int stress_cycles = 500;
    localparam int drain_limit = 200;
    // Reads reach their queue two cycles after the AFU strobe, hence the slack
    localparam int backlog_limit = mpf_pkg::queue_depth - 2;
    localparam int total_cycles = reset_cycles + idle_cycles + basic_cycles
        + pt_rounds * (pt_cycles + 8) + order_cycles + stress_cycles;

    logic clk;
    logic reset;
    logic afu_rd_valid;
    mpf_pkg::mpf_rd_req_t afu_rd_req;
    logic afu_wr_valid;
    mpf_pkg::mpf_wr_req_t afu_wr_req;
    logic pt_valid;
    mpf_pkg::mpf_pt_wr_t pt_wr;
    logic afu_rsp_valid;
    logic [mpf_pkg::data_width-1:0] afu_rsp_data;
    logic afu_wr_done;
    logic fiu_req_valid;
    mpf_pkg::mpf_fiu_req_t fiu_req;
    logic fiu_rd_rsp_valid;
    mpf_pkg::mpf_rd_rsp_t fiu_rd_rsp;
    logic fiu_wr_rsp_valid;

    // Reference model state
    logic [31:0] rng_state;
    mpf_pkg::ppn_t model_pt [mpf_pkg::pt_entries];
    mpf_pkg::data_t model_mem [logic [mpf_pkg::addr_width-1:0]];
    mpf_pkg::mpf_fiu_req_t exp_rd_q [$];
    mpf_pkg::mpf_fiu_req_t exp_wr_q [$];
    mpf_pkg::data_t exp_data_q [$];

    // Client contract counters and bookkeeping
    int backlog;
    int rd_outstanding;
    int max_outstanding;
    int rd_issued;
    int wr_issued;
    int wr_done_count;
    int error_count;
    int test_count;
    int failed_tests;
    int test_first_error;

    mpf_shim_stack mpf_shim_stack_i (
        .clk(clk),
        .reset(reset),
        .afu_rd_valid(afu_rd_valid),
        .afu_rd_req(afu_rd_req),
        .afu_wr_valid(afu_wr_valid),
        .afu_wr_req(afu_wr_req),
        .pt_valid(pt_valid),
        .pt_wr(pt_wr),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_data(afu_rsp_data),
        .afu_wr_done(afu_wr_done),
        .fiu_req_valid(fiu_req_valid),
        .fiu_req(fiu_req),
        .fiu_rd_rsp_valid(fiu_rd_rsp_valid),
        .fiu_rd_rsp(fiu_rd_rsp),
        .fiu_wr_rsp_valid(fiu_wr_rsp_valid)
    );

    mpf_mem_model mem_model_i (
        .clk(clk),
        .reset(reset),
        .req_valid(fiu_req_valid),
        .req(fiu_req),
        .rd_rsp_valid(fiu_rd_rsp_valid),
        .rd_rsp(fiu_rd_rsp),
        .wr_rsp_valid(fiu_wr_rsp_valid)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(input int unsigned range, output int unsigned value);
        rng_state = lcg_next(rng_state);
        value = (rng_state >> 16) % range;
    endtask

    // Virtual page replaced by the model's table entry, offset kept
    function automatic mpf_pkg::addr_t translate(input mpf_pkg::addr_t vaddr);
        return {model_pt[vaddr[mpf_pkg::page_bits +: mpf_pkg::pt_index_width]],
                vaddr[mpf_pkg::page_bits-1:0]};
    endfunction

    // Few lines per page so reads often hit earlier writes
    task automatic random_addr(output mpf_pkg::addr_t addr);
        int unsigned page;
        int unsigned line;
        draw(mpf_pkg::pt_entries, page);
        draw(8, line);
        addr = '0;
        addr[mpf_pkg::page_bits +: mpf_pkg::pt_index_width] = mpf_pkg::pt_index_t'(page);
        addr[2:0] = 3'(line);
    endtask

    // One clock of stimulus, each channel fires with its percentage when the limits allow
    task automatic step(input int unsigned rd_pct, input int unsigned wr_pct);
        int unsigned roll;
        logic do_rd;
        logic do_wr;
        mpf_pkg::addr_t addr;
        mpf_pkg::mpf_fiu_req_t exp;
        mpf_pkg::mpf_rd_req_t rd_req;
        mpf_pkg::mpf_wr_req_t wr_req;
        @(posedge clk);
        // The arbiter retires one request in every cycle with a backlog
        if (backlog > 0) begin
            backlog = backlog - 1;
        end
        draw(100, roll);
        do_rd = (roll < rd_pct) && (rd_outstanding < mpf_pkg::rob_depth)
            && (backlog + 1 < backlog_limit);
        draw(100, roll);
        do_wr = (roll < wr_pct) && (backlog + int'(do_rd) + 1 < backlog_limit);
        afu_rd_valid <= do_rd;
        afu_wr_valid <= do_wr;
        pt_valid <= 1'b0;
        if (do_rd) begin
            random_addr(addr);
            rd_req.addr = addr;
            // Junk tag on input, the stack assigns its own
            rd_req.tag = mpf_pkg::tag_t'(roll);
            afu_rd_req <= rd_req;
            exp = '0;
            exp.addr = translate(addr);
            exp.tag = mpf_pkg::tag_t'(rd_issued % mpf_pkg::rob_depth);
            exp_rd_q.push_back(exp);
            rd_issued++;
            rd_outstanding++;
            backlog++;
        end
        if (do_wr) begin
            random_addr(addr);
            rng_state = lcg_next(rng_state);
            wr_req.addr = addr;
            wr_req.data = {rng_state, lcg_next(rng_state)};
            afu_wr_req <= wr_req;
            exp = '0;
            exp.is_write = 1'b1;
            exp.addr = translate(addr);
            exp.data = wr_req.data;
            exp_wr_q.push_back(exp);
            wr_issued++;
            backlog++;
        end
        if (rd_outstanding > max_outstanding) begin
            max_outstanding = rd_outstanding;
        end
    endtask

    // Random table entries, then four quiet cycles before any request may depend on them
    task automatic load_page_table(input int count);
        int unsigned idx;
        int unsigned ppn;
        mpf_pkg::mpf_pt_wr_t entry;
        repeat (count) begin
            @(posedge clk);
            draw(mpf_pkg::pt_entries, idx);
            draw(1 << mpf_pkg::ppn_width, ppn);
            entry.index = mpf_pkg::pt_index_t'(idx);
            entry.ppn = mpf_pkg::ppn_t'(ppn);
            afu_rd_valid <= 1'b0;
            afu_wr_valid <= 1'b0;
            pt_valid <= 1'b1;
            pt_wr <= entry;
            model_pt[idx] = entry.ppn;
        end
        repeat (4) step(0, 0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_rd_q.size() + exp_wr_q.size() + exp_data_q.size() != 0
                || rd_outstanding != 0 || wr_done_count != wr_issued)
               && waited < drain_limit) begin
            step(0, 0);
            waited++;
        end
        assert (waited < drain_limit) else begin
            $display("Requests or responses still missing after %0d idle cycles", drain_limit);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == test_first_error) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", test_count, name, error_count - test_first_error);
        end
        test_first_error = error_count;
    endtask

    // ====================
    // Output monitor
    // ====================

    // Sampled on the falling edge, well away from the stimulus edge
    always @(negedge clk) begin : monitor
        mpf_pkg::mpf_fiu_req_t exp;
        mpf_pkg::data_t exp_data;
        if (!reset && fiu_req_valid && fiu_req.is_write) begin
            assert (exp_wr_q.size() > 0) else begin
                $display("Write request on the FIU bus with no write outstanding");
                error_count++;
            end
            if (exp_wr_q.size() > 0) begin
                exp = exp_wr_q.pop_front();
                assert (fiu_req.addr == exp.addr) else begin
                    $display("Error: fiu_req.addr expected %h got %h", exp.addr, fiu_req.addr);
                    error_count++;
                end
                assert (fiu_req.data == exp.data) else begin
                    $display("Error: fiu_req.data expected %h got %h", exp.data, fiu_req.data);
                    error_count++;
                end
                model_mem[exp.addr] = exp.data;
            end
        end
        if (!reset && fiu_req_valid && !fiu_req.is_write) begin
            assert (exp_rd_q.size() > 0) else begin
                $display("Read request on the FIU bus with no read outstanding");
                error_count++;
            end
            if (exp_rd_q.size() > 0) begin
                exp = exp_rd_q.pop_front();
                assert (fiu_req.addr == exp.addr) else begin
                    $display("Error: fiu_req.addr expected %h got %h", exp.addr, fiu_req.addr);
                    error_count++;
                end
                assert (fiu_req.tag == exp.tag) else begin
                    $display("Error: fiu_req.tag expected %h got %h", exp.tag, fiu_req.tag);
                    error_count++;
                end
                // Data is fixed by the writes that reached the bus ahead of this read
                exp_data_q.push_back(model_mem.exists(exp.addr) ? model_mem[exp.addr]
                                                                : mpf_pkg::data_t'(exp.addr));
            end
        end
        if (!reset && afu_rsp_valid) begin
            assert (exp_data_q.size() > 0) else begin
                $display("Read response on the AFU side before its request reached memory");
                error_count++;
            end
            if (exp_data_q.size() > 0) begin
                exp_data = exp_data_q.pop_front();
                assert (afu_rsp_data == exp_data) else begin
                    $display("Error: afu_rsp_data expected %h got %h", exp_data, afu_rsp_data);
                    error_count++;
                end
            end
            rd_outstanding--;
        end
        if (!reset && afu_wr_done) begin
            wr_done_count++;
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial begin : main
        int first_read;
        rng_state = 32'hd41a;
        reset = 1'b1;
        afu_rd_valid = 1'b0;
        afu_rd_req = '0;
        afu_wr_valid = 1'b0;
        afu_wr_req = '0;
        pt_valid = 1'b0;
        pt_wr = '0;
        backlog = 0;
        rd_outstanding = 0;
        max_outstanding = 0;
        rd_issued = 0;
        wr_issued = 0;
        wr_done_count = 0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        test_first_error = 0;
        for (int i = 0; i < mpf_pkg::pt_entries; i++) begin
            model_pt[i] = mpf_pkg::ppn_t'(i);
        end
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        repeat (idle_cycles) begin
            @(negedge clk);
            assert (!fiu_req_valid && !afu_rsp_valid && !afu_wr_done) else begin
                $display("Error: fiu_req_valid %h afu_rsp_valid %h afu_wr_done %h after reset",
                         fiu_req_valid, afu_rsp_valid, afu_wr_done);
                error_count++;
            end
        end
        report_test("quiet after reset");

        repeat (basic_cycles) step(40, 40);
        drain();
        report_test("identity table traffic");

        repeat (pt_rounds) begin
            load_page_table(4);
            repeat (pt_cycles) step(40, 40);
            drain();
        end
        report_test("page table translation");

        repeat (order_cycles) step(50, 50);
        drain();
        report_test("read order and data");

        // Reads only, as many in flight as the reorder buffer holds
        max_outstanding = 0;
        first_read = rd_issued;
        repeat (stress_cycles) step(100, 0);
        drain();
        assert (max_outstanding == mpf_pkg::rob_depth) else begin
            $display("Stress run never reached a full reorder buffer");
            error_count++;
        end
        assert (rd_issued - first_read >= 3 * mpf_pkg::rob_depth) else begin
            $display("Stress run issued too few reads to wrap the tags several times");
            error_count++;
        end
        report_test("reorder buffer stress");

        assert (wr_done_count == wr_issued) else begin
            $display("Error: afu_wr_done count expected %h got %h", wr_issued, wr_done_count);
            error_count++;
        end
        report_test("write completions");

        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Ends a run that stalls, with room for twice the expected length
    initial begin : watchdog
        #(total_cycles * clk_period * 2 + 20000);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== test/mpf_mem_model.sv ====
// FIU-side memory model with sparse storage, random latency and out-of-order read returns
`timescale 1ns/10ps

module mpf_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mpf_pkg::mpf_fiu_req_t req,
    output logic                  rd_rsp_valid,
    output mpf_pkg::mpf_rd_rsp_t  rd_rsp,
    output logic                  wr_rsp_valid
);

    // Sparse line storage keyed by physical address
    mpf_pkg::data_t mem [logic [mpf_pkg::addr_width-1:0]];

    // Reads waiting for their return cycle, kept in arrival order
    mpf_pkg::mpf_rd_rsp_t rd_pend [$];
    int unsigned rd_due [$];

    // Writes only owe a completion strobe
    int unsigned wr_due [$];

    int unsigned cycle;
    logic [31:0] rng_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory is idle with no responses pending before the first clock edge
    initial begin
        rd_rsp_valid = 1'b0;
        rd_rsp = '0;
        wr_rsp_valid = 1'b0;
    end

    always @(posedge clk) begin : serve
        int rd_idx;
        int wr_idx;
        int unsigned delay;
        mpf_pkg::mpf_rd_rsp_t entry;
        if (reset) begin
            rd_pend.delete();
            rd_due.delete();
            wr_due.delete();
            cycle = 0;
            rng_state = 32'hd41a;
            rd_rsp_valid <= 1'b0;
            rd_rsp <= '0;
            wr_rsp_valid <= 1'b0;
        end else begin
            cycle = cycle + 1;
            rd_idx = -1;
            wr_idx = -1;
            // The first due read goes out, so a quick later read overtakes a slow earlier one
            for (int i = 0; i < rd_due.size(); i++) begin
                if (rd_idx < 0 && rd_due[i] <= cycle) begin
                    rd_idx = i;
                end
            end
            for (int i = 0; i < wr_due.size(); i++) begin
                if (wr_idx < 0 && wr_due[i] <= cycle) begin
                    wr_idx = i;
                end
            end
            rd_rsp_valid <= (rd_idx >= 0);
            wr_rsp_valid <= (wr_idx >= 0);
            if (rd_idx >= 0) begin
                rd_rsp <= rd_pend[rd_idx];
                rd_pend.delete(rd_idx);
                rd_due.delete(rd_idx);
            end
            if (wr_idx >= 0) begin
                wr_due.delete(wr_idx);
            end
            // Memory state changes in bus order, read data is captured on arrival
            if (req_valid) begin
                rng_state = lcg_next(rng_state);
                delay = 32'd1 + ((rng_state >> 16) % 32'd12);
                if (req.is_write) begin
                    mem[req.addr] = req.data;
                    wr_due.push_back(cycle + delay);
                end else begin
                    entry.tag = req.tag;
                    // An untouched line reads back as its own address
                    entry.data = mem.exists(req.addr) ? mem[req.addr] : mpf_pkg::data_t'(req.addr);
                    rd_pend.push_back(entry);
                    rd_due.push_back(cycle + delay);
                end
            end
        end
    end

endmodule

// ==== hw/mpf_shim_stack.sv ====
// Top level of the MPF stack with response ordering, channel arbitration and translation
`timescale 1ns/10ps

module mpf_shim_stack (
    input  logic                           clk,
    input  logic                           reset,

    // AFU side
    input  logic                           afu_rd_valid,
    input  mpf_pkg::mpf_rd_req_t           afu_rd_req,
    input  logic                           afu_wr_valid,
    input  mpf_pkg::mpf_wr_req_t           afu_wr_req,
    input  logic                           pt_valid,
    input  mpf_pkg::mpf_pt_wr_t            pt_wr,
    output logic                           afu_rsp_valid,
    output logic [mpf_pkg::data_width-1:0] afu_rsp_data,
    output logic                           afu_wr_done,

    // FIU side
    output logic                           fiu_req_valid,
    output mpf_pkg::mpf_fiu_req_t          fiu_req,
    input  logic                           fiu_rd_rsp_valid,
    input  mpf_pkg::mpf_rd_rsp_t           fiu_rd_rsp,
    input  logic                           fiu_wr_rsp_valid
);

    // Tagged reads heading for the arbiter
    logic tagged_valid;
    mpf_pkg::mpf_rd_req_t tagged_req;

    // Merged requests still carrying virtual addresses
    logic virt_valid;
    mpf_pkg::mpf_fiu_req_t virt_req;

    // ====================
    // Response ordering
    // ====================

    mpf_rsp_order rsp_order_i (
        .clk(clk),
        .reset(reset),
        .afu_rd_valid(afu_rd_valid),
        .afu_rd_req(afu_rd_req),
        .tagged_valid(tagged_valid),
        .tagged_req(tagged_req),
        .rsp_valid(fiu_rd_rsp_valid),
        .rsp(fiu_rd_rsp),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_data(afu_rsp_data)
    );

    // Writes need no tag and go straight into their queue
    mpf_chan_arbiter chan_arbiter_i (
        .clk(clk),
        .reset(reset),
        .rd_valid(tagged_valid),
        .rd_req(tagged_req),
        .wr_valid(afu_wr_valid),
        .wr_req(afu_wr_req),
        .out_valid(virt_valid),
        .out_req(virt_req)
    );

    // Translation sits nearest the FIU
    mpf_vtp vtp_i (
        .clk(clk),
        .reset(reset),
        .pt_valid(pt_valid),
        .pt_wr(pt_wr),
        .in_valid(virt_valid),
        .in_req(virt_req),
        .out_valid(fiu_req_valid),
        .out_req(fiu_req)
    );

    // Write completions are only counted by the AFU, so they pass with one register
    always_ff @(posedge clk) begin
        if (reset) begin
            afu_wr_done <= 1'b0;
        end else begin
            afu_wr_done <= fiu_wr_rsp_valid;
        end
    end

endmodule

// ==== hw/mpf_rsp_order.sv ====
// Read tag allocation and reorder buffer returning read data in request order
`timescale 1ns/10ps

module mpf_rsp_order (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 afu_rd_valid,
    input  mpf_pkg::mpf_rd_req_t                 afu_rd_req,
    output logic                                 tagged_valid,
    output mpf_pkg::mpf_rd_req_t                 tagged_req,
    input  logic                                 rsp_valid,
    input  mpf_pkg::mpf_rd_rsp_t                 rsp,
    output logic                                 afu_rsp_valid,
    output logic [mpf_pkg::data_width-1:0]       afu_rsp_data
);

    // Next tag handed to a new read
    mpf_pkg::tag_t alloc_ptr;

    // Oldest tag not yet returned to the AFU
    mpf_pkg::tag_t head_ptr;

    // Reorder buffer, one slot per tag
    mpf_pkg::data_t rob_data [mpf_pkg::rob_depth];
    logic [mpf_pkg::rob_depth-1:0] rob_filled;

    // The head slot is ready once its response has arrived
    logic head_ready;

    // ====================
    // Request path
    // ====================

    // Tags follow request order, wrapping at rob_depth
    // The client caps outstanding reads, so a live tag is never reused
    always_ff @(posedge clk) begin
        if (reset) begin
            alloc_ptr <= '0;
            tagged_valid <= 1'b0;
        end else begin
            tagged_valid <= afu_rd_valid;
            if (afu_rd_valid) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
        end
    end

    // Incoming tag field is discarded and replaced by the allocated one
    always_ff @(posedge clk) begin
        tagged_req.addr <= afu_rd_req.addr;
        tagged_req.tag <= alloc_ptr;
    end

    // ====================
    // Response path
    // ====================

    assign head_ready = rob_filled[head_ptr];

    // Head slot is presented directly from the buffer
    // so data shows up the cycle after the slot fills
    assign afu_rsp_valid = head_ready;
    assign afu_rsp_data = rob_data[head_ptr];

    // Filled bits and the head pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            rob_filled <= '0;
            head_ptr <= '0;
        end else begin
            // Drain the head slot and move to the next tag
            if (head_ready) begin
                rob_filled[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
            // Out-of-order arrival marks its own slot
            if (rsp_valid) begin
                rob_filled[rsp.tag] <= 1'b1;
            end
        end
    end

    // Slot data, indexed by the tag carried back from memory
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            rob_data[rsp.tag] <= rsp.data;
        end
    end

endmodule

// ==== hw/mpf_vtp.sv ====
// Page table and registered virtual-to-physical address rewrite stage
`timescale 1ns/10ps

module mpf_vtp (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pt_valid,
    input  mpf_pkg::mpf_pt_wr_t   pt_wr,
    input  logic                  in_valid,
    input  mpf_pkg::mpf_fiu_req_t in_req,
    output logic                  out_valid,
    output mpf_pkg::mpf_fiu_req_t out_req
);

    // One physical page number per virtual page index
    mpf_pkg::ppn_t page_table [mpf_pkg::pt_entries];

    // Index taken from the bits just above the page offset
    mpf_pkg::pt_index_t vpn_index;

    // Request with its page already replaced
    mpf_pkg::mpf_fiu_req_t xlate_req;

    assign vpn_index = in_req.addr[mpf_pkg::page_bits +: mpf_pkg::pt_index_width];

    // ====================
    // Translation
    // ====================

    // Only the address changes, the flag, data and tag pass along unchanged
    always_comb begin
        xlate_req = in_req;
        xlate_req.addr = {page_table[vpn_index], in_req.addr[mpf_pkg::page_bits-1:0]};
    end

    // ====================
    // Page table
    // ====================

    // Reset loads the identity mapping
    // A host write lands at the clock edge, so a request in the same cycle
    // still sees the old entry and the next one sees the new entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mpf_pkg::pt_entries; i++) begin
                page_table[i] <= mpf_pkg::ppn_t'(i);
            end
        end else if (pt_valid) begin
            page_table[pt_wr.index] <= pt_wr.ppn;
        end
    end

    // ====================
    // Output stage
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload register, meaningful only with out_valid
    always_ff @(posedge clk) begin
        out_req <= xlate_req;
    end

endmodule

// ==== hw/mpf_chan_arbiter.sv ====
// Round-robin arbiter merging the read and write request queues onto one FIU request bus
`timescale 1ns/10ps

module mpf_chan_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_valid,
    input  mpf_pkg::mpf_rd_req_t  rd_req,
    input  logic                  wr_valid,
    input  mpf_pkg::mpf_wr_req_t  wr_req,
    output logic                  out_valid,
    output mpf_pkg::mpf_fiu_req_t out_req
);

    // Queue heads and their state
    mpf_pkg::mpf_rd_req_t rd_head;
    mpf_pkg::mpf_wr_req_t wr_head;
    logic rd_empty;
    logic wr_empty;

    // Grants for this cycle, at most one is set
    logic grant_rd;
    logic grant_wr;

    // Set when the last grant went to the write channel
    logic last_grant_wr;

    // Winning request converted to the FIU format
    mpf_pkg::mpf_fiu_req_t next_req;

    // ====================
    // Channel queues
    // ====================

    mpf_req_queue #(
        .payload_t(mpf_pkg::mpf_rd_req_t)
    ) rd_queue_i (
        .clk(clk),
        .reset(reset),
        .push(rd_valid),
        .push_data(rd_req),
        .pop(grant_rd),
        .pop_data(rd_head),
        .empty(rd_empty)
    );

    mpf_req_queue #(
        .payload_t(mpf_pkg::mpf_wr_req_t)
    ) wr_queue_i (
        .clk(clk),
        .reset(reset),
        .push(wr_valid),
        .push_data(wr_req),
        .pop(grant_wr),
        .pop_data(wr_head),
        .empty(wr_empty)
    );

    // ====================
    // Arbitration
    // ====================

    // Read wins when it is alone or when write had the previous turn
    assign grant_rd = !rd_empty && (wr_empty || last_grant_wr);
    assign grant_wr = !wr_empty && !grant_rd;

    // Reads carry their tag, writes carry the flag and their data
    always_comb begin
        next_req = '0;
        if (grant_wr) begin
            next_req.is_write = 1'b1;
            next_req.addr = wr_head.addr;
            next_req.data = wr_head.data;
        end else begin
            next_req.addr = rd_head.addr;
            next_req.tag = rd_head.tag;
        end
    end

    // After reset write counts as the last winner, so read goes first
    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant_wr <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant_rd || grant_wr;
            if (grant_rd || grant_wr) begin
                last_grant_wr <= grant_wr;
            end
        end
    end

    // Payload register, qualified by out_valid
    always_ff @(posedge clk) begin
        out_req <= next_req;
    end

endmodule

// ==== hw/mpf_req_queue.sv ====
// Circular-buffer FIFO with a type parameter for one request channel
`timescale 1ns/10ps

module mpf_req_queue #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    // Pointers carry one extra wrap bit so that full and empty differ
    logic [mpf_pkg::queue_addr_width:0] wr_ptr;
    logic [mpf_pkg::queue_addr_width:0] rd_ptr;

    // Storage for the queued payloads
    payload_t mem [mpf_pkg::queue_depth];

    // Both pointers match only when every pushed entry has been popped
    assign empty = (wr_ptr == rd_ptr);

    // Head entry is offered combinationally so the arbiter can register it on pop
    assign pop_data = mem[rd_ptr[mpf_pkg::queue_addr_width-1:0]];

    // ====================
    // Pointer control
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // The client never pushes into a full queue
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // A pop while empty is dropped
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // An entry written here is visible at the head in the following cycle
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[mpf_pkg::queue_addr_width-1:0]] <= push_data;
        end
    end

endmodule

// ==== hw/mpf_pkg.sv ====
// Shared localparams and packed request, response and page-table write structs for the MPF stack
package mpf_pkg;

    // ====================
    // Sizes
    // ====================

    // Line address width as seen on both the AFU and the FIU side
    localparam int addr_width = 32;

    // Page offset width, kept untouched by translation
    localparam int page_bits = 12;

    // Page table size and the width of its index
    localparam int pt_entries = 16;
    localparam int pt_index_width = $clog2(pt_entries);

    // A physical page number fills everything above the offset
    localparam int ppn_width = addr_width - page_bits;

    // Line payload width
    localparam int data_width = 64;

    // Reorder buffer slots, one per outstanding read tag
    localparam int rob_depth = 16;
    localparam int tag_width = $clog2(rob_depth);

    // Depth of each channel queue in front of the arbiter
    localparam int queue_depth = 8;
    localparam int queue_addr_width = $clog2(queue_depth);

    // ====================
    // Field types
    // ====================

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [ppn_width-1:0] ppn_t;
    typedef logic [pt_index_width-1:0] pt_index_t;

    // ====================
    // Channel payloads
    // ====================

    // Read request from the AFU, tagged on its way into the stack
    typedef struct packed {
        addr_t addr;
        tag_t tag;
    } mpf_rd_req_t;

    // Write request from the AFU
    typedef struct packed {
        addr_t addr;
        data_t data;
    } mpf_wr_req_t;

    // Merged request on the FIU bus, data is meaningful for writes and tag for reads
    typedef struct packed {
        logic is_write;
        addr_t addr;
        data_t data;
        tag_t tag;
    } mpf_fiu_req_t;

    // Read response from memory, possibly out of order
    typedef struct packed {
        tag_t tag;
        data_t data;
    } mpf_rd_rsp_t;

    // Host write into the page table
    typedef struct packed {
        pt_index_t index;
        ppn_t ppn;
    } mpf_pt_wr_t;

endpackage
